// File: include/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 30
`define SOC_BE_W 4

// Prefix widths, counted from the top of the word address
`define SOC_TOP_SEL_W 2
`define SOC_PERIPH_SEL_W 10
`define SOC_SMALL_SEL_W 20

// Top-level region codes
`define SOC_TOP_PERIPH 3

// Codes inside the peripheral region
`define SOC_PERIPH_RAM 0
`define SOC_PERIPH_SMALL 255

// Small-peripheral indices
`define SOC_SMALL_GPIO 2
`define SOC_SMALL_TIMER 9

// RAM size in words
`define SOC_RAM_DEPTH 1024

`endif

// File: source/socPkg.sv
`include "soc_cfg.svh"

package socPkg;

    // Word address as seen on the data bus
    typedef logic [`SOC_ADDR_W-1:0] busAddr_t;

    // One bus data word
    typedef logic [`SOC_DATA_W-1:0] busData_t;

    // One enable bit per byte lane
    typedef logic [`SOC_BE_W-1:0] byteEn_t;

    // Offset left below the RAM prefix
    // Small peripherals only look at the low bits
    typedef logic [`SOC_ADDR_W-`SOC_PERIPH_SEL_W-1:0] regAddr_t;

endpackage

// File: source/slaveBusIf.sv
`timescale 1ns/1ps

interface slaveBusIf;
    import socPkg::*;

    // Request side, driven by the decoder
    logic     sel;
    regAddr_t regAddr;
    byteEn_t  byteEn;
    logic     read;
    logic     write;
    busData_t writeData;

    // Return side, zero while sel is low
    busData_t readData;
    logic     waitRequest;

    modport master (
        output sel, regAddr, byteEn, read, write, writeData,
        input  readData, waitRequest
    );

    modport slave (
        input  sel, regAddr, byteEn, read, write, writeData,
        output readData, waitRequest
    );

endinterface

// File: source/dbusDecoder.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module dbusDecoder (
    input  socPkg::busAddr_t i_busAddr,
    input  socPkg::byteEn_t  i_busByteEn,
    input  logic             i_busRead,
    input  logic             i_busWrite,
    input  socPkg::busData_t i_busWriteData,
    output socPkg::busData_t o_busReadData,
    output logic             o_busWaitRequest,
    slaveBusIf.master        ramBus,
    slaveBusIf.master        gpioBus,
    slaveBusIf.master        timerBus
);
    import socPkg::*;

    localparam int TopW = `SOC_TOP_SEL_W;
    localparam int PeriphCodeW = `SOC_PERIPH_SEL_W - `SOC_TOP_SEL_W;
    localparam int SmallIdxW = `SOC_SMALL_SEL_W - `SOC_PERIPH_SEL_W;
    localparam int SmallRegW = `SOC_ADDR_W - `SOC_SMALL_SEL_W;

    localparam logic [TopW-1:0] TopPeriph = TopW'(`SOC_TOP_PERIPH);
    localparam logic [PeriphCodeW-1:0] PeriphRam = PeriphCodeW'(`SOC_PERIPH_RAM);
    localparam logic [PeriphCodeW-1:0] PeriphSmall = PeriphCodeW'(`SOC_PERIPH_SMALL);
    localparam logic [SmallIdxW-1:0] SmallGpio = SmallIdxW'(`SOC_SMALL_GPIO);
    localparam logic [SmallIdxW-1:0] SmallTimer = SmallIdxW'(`SOC_SMALL_TIMER);

    // Address fields, top down
    logic [TopW-1:0]        topField;
    logic [PeriphCodeW-1:0] periphField;
    logic [SmallIdxW-1:0]   smallField;
    regAddr_t               periphRegAddr;
    regAddr_t               smallRegAddr;
    logic                   inPeriph;
    logic                   inSmall;

    assign topField      = i_busAddr[`SOC_ADDR_W-1 -: TopW];
    assign periphField   = i_busAddr[`SOC_ADDR_W-TopW-1 -: PeriphCodeW];
    assign smallField    = i_busAddr[`SOC_ADDR_W-`SOC_PERIPH_SEL_W-1 -: SmallIdxW];
    assign periphRegAddr = i_busAddr[`SOC_ADDR_W-`SOC_PERIPH_SEL_W-1:0];
    assign smallRegAddr  = regAddr_t'(i_busAddr[SmallRegW-1:0]);

    // Region, then block, then slave index
    assign inPeriph = (topField == TopPeriph);
    assign inSmall  = inPeriph && (periphField == PeriphSmall);

    assign ramBus.sel   = inPeriph && (periphField == PeriphRam);
    assign gpioBus.sel  = inSmall && (smallField == SmallGpio);
    assign timerBus.sel = inSmall && (smallField == SmallTimer);

    assign ramBus.regAddr   = periphRegAddr;
    assign gpioBus.regAddr  = smallRegAddr;
    assign timerBus.regAddr = smallRegAddr;

    // Strobes and data go to every slave, sel picks the one that acts
    assign ramBus.byteEn    = i_busByteEn;
    assign ramBus.read      = i_busRead;
    assign ramBus.write     = i_busWrite;
    assign ramBus.writeData = i_busWriteData;

    assign gpioBus.byteEn    = i_busByteEn;
    assign gpioBus.read      = i_busRead;
    assign gpioBus.write     = i_busWrite;
    assign gpioBus.writeData = i_busWriteData;

    assign timerBus.byteEn    = i_busByteEn;
    assign timerBus.read      = i_busRead;
    assign timerBus.write     = i_busWrite;
    assign timerBus.writeData = i_busWriteData;

    // Unselected slaves return zero, so a plain OR merges them
    assign o_busReadData = ramBus.readData | gpioBus.readData | timerBus.readData;
    assign o_busWaitRequest = ramBus.waitRequest | gpioBus.waitRequest
                            | timerBus.waitRequest;

endmodule

// File: source/ramSlave.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module ramSlave #(
    parameter int DEPTH = `SOC_RAM_DEPTH
) (
    input logic       w_SysClk,
    input logic       i_rst,
    slaveBusIf.slave  bus
);
    import socPkg::*;

    localparam int IdxW = $clog2(DEPTH);

    busData_t        mem [DEPTH];
    busData_t        readWord;
    logic            readPending;
    logic [IdxW-1:0] wordIdx;
    logic            readReq;

    assign wordIdx = bus.regAddr[IdxW-1:0];
    assign readReq = bus.sel && bus.read;

    // First read cycle stalls, second one returns the registered word
    assign bus.waitRequest = readReq && !readPending;
    assign bus.readData    = (readReq && readPending) ? readWord : '0;

    always_ff @(posedge w_SysClk) begin
        if (i_rst) begin
            readPending <= 1'b0;
        end else begin
            readPending <= readReq && !readPending;
        end
    end

    always_ff @(posedge w_SysClk) begin
        if (readReq && !readPending) begin
            readWord <= mem[wordIdx];
        end
    end

    // Byte lanes written independently
    always_ff @(posedge w_SysClk) begin
        if (bus.sel && bus.write) begin
            for (int b = 0; b < `SOC_BE_W; b++) begin
                if (bus.byteEn[b]) begin
                    mem[wordIdx][8*b +: 8] <= bus.writeData[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: source/sevenSegGpio.sv
`timescale 1ns/1ps

module sevenSegGpio (
    input  logic       w_SysClk,
    input  logic       i_rst,
    slaveBusIf.slave   bus,
    output logic [2:0] o_sevenSegEn,
    output logic [6:0] o_sevenSegLed
);
    import socPkg::*;

    localparam regAddr_t EnOffset  = regAddr_t'(0);
    localparam regAddr_t LedOffset = regAddr_t'(1);

    logic regWrite;

    // Only the low byte lane carries register bits
    assign regWrite = bus.sel && bus.write && bus.byteEn[0];

    always_ff @(posedge w_SysClk) begin
        if (i_rst) begin
            o_sevenSegEn  <= '0;
            o_sevenSegLed <= '0;
        end else if (regWrite) begin
            if (bus.regAddr == EnOffset) begin
                o_sevenSegEn <= bus.writeData[2:0];
            end
            if (bus.regAddr == LedOffset) begin
                o_sevenSegLed <= bus.writeData[6:0];
            end
        end
    end

    always_comb begin
        bus.readData = '0;
        if (bus.sel && bus.read) begin
            if (bus.regAddr == EnOffset) begin
                bus.readData = busData_t'(o_sevenSegEn);
            end else if (bus.regAddr == LedOffset) begin
                bus.readData = busData_t'(o_sevenSegLed);
            end
        end
    end

    // Register access never stalls
    assign bus.waitRequest = 1'b0;

endmodule

// File: source/timerSlave.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module timerSlave (
    input logic      w_SysClk,
    input logic      i_rst,
    slaveBusIf.slave bus
);
    import socPkg::*;

    localparam regAddr_t CtrlOffset    = regAddr_t'(0);
    localparam regAddr_t CountOffset   = regAddr_t'(1);
    localparam regAddr_t CompareOffset = regAddr_t'(2);
    localparam regAddr_t StatusOffset  = regAddr_t'(3);

    logic     enable;
    busData_t count;
    busData_t compare;
    logic     matchFlag;
    logic     busWrite;
    logic     matchHit;
    logic     matchClr;

    function automatic busData_t mergeBytes(busData_t oldWord, busData_t newWord, byteEn_t be);
        busData_t result;
        result = oldWord;
        for (int b = 0; b < `SOC_BE_W; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign busWrite = bus.sel && bus.write;
    assign matchHit = enable && (count == compare);
    assign matchClr = busWrite && (bus.regAddr == StatusOffset)
                    && bus.byteEn[0] && bus.writeData[0];

    always_ff @(posedge w_SysClk) begin
        if (i_rst) begin
            enable    <= 1'b0;
            count     <= '0;
            compare   <= '0;
            matchFlag <= 1'b0;
        end else begin
            if (busWrite && bus.regAddr == CtrlOffset && bus.byteEn[0]) begin
                enable <= bus.writeData[0];
            end
            // Bus write wins over the increment
            if (busWrite && bus.regAddr == CountOffset) begin
                count <= mergeBytes(count, bus.writeData, bus.byteEn);
            end else if (enable) begin
                count <= count + 1'b1;
            end
            if (busWrite && bus.regAddr == CompareOffset) begin
                compare <= mergeBytes(compare, bus.writeData, bus.byteEn);
            end
            // A new match beats a clear in the same cycle
            matchFlag <= (matchFlag && !matchClr) || matchHit;
        end
    end

    always_comb begin
        bus.readData = '0;
        if (bus.sel && bus.read) begin
            case (bus.regAddr)
                CtrlOffset:    bus.readData = busData_t'(enable);
                CountOffset:   bus.readData = count;
                CompareOffset: bus.readData = compare;
                StatusOffset:  bus.readData = busData_t'(matchFlag);
                default:       bus.readData = '0;
            endcase
        end
    end

    assign bus.waitRequest = 1'b0;

endmodule

// File: source/socTop.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module socTop (
    input  logic             w_SysClk,
    input  logic             i_rst,

    // Data bus from the external master
    input  socPkg::busAddr_t i_busAddr,
    input  socPkg::byteEn_t  i_busByteEn,
    input  logic             i_busRead,
    input  logic             i_busWrite,
    input  socPkg::busData_t i_busWriteData,
    output socPkg::busData_t o_busReadData,
    output logic             o_busWaitRequest,

    // Display
    output logic [2:0]       o_sevenSegEn,
    output logic [6:0]       o_sevenSegLed
);

    slaveBusIf ramBus ();
    slaveBusIf gpioBus ();
    slaveBusIf timerBus ();

    dbusDecoder dbusDecoder_inst (
        .i_busAddr        (i_busAddr),
        .i_busByteEn      (i_busByteEn),
        .i_busRead        (i_busRead),
        .i_busWrite       (i_busWrite),
        .i_busWriteData   (i_busWriteData),
        .o_busReadData    (o_busReadData),
        .o_busWaitRequest (o_busWaitRequest),
        .ramBus           (ramBus.master),
        .gpioBus          (gpioBus.master),
        .timerBus         (timerBus.master)
    );

    ramSlave #(
        .DEPTH (`SOC_RAM_DEPTH)
    ) ramSlave_inst (
        .w_SysClk (w_SysClk),
        .i_rst    (i_rst),
        .bus      (ramBus.slave)
    );

    sevenSegGpio sevenSegGpio_inst (
        .w_SysClk      (w_SysClk),
        .i_rst         (i_rst),
        .bus           (gpioBus.slave),
        .o_sevenSegEn  (o_sevenSegEn),
        .o_sevenSegLed (o_sevenSegLed)
    );

    timerSlave timerSlave_inst (
        .w_SysClk (w_SysClk),
        .i_rst    (i_rst),
        .bus      (timerBus.slave)
    );

endmodule

// File: test/socTb.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module socTb;
    import socPkg::*;

    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 10;
    localparam int RamWrites = 64;
    localparam int ByteEnWrites = 16;
    localparam int CountGap = 25;
    localparam int OpCount = 220;
    localparam int TimeoutCycles = 2000 + 4 * OpCount;
    localparam int TopShift = `SOC_ADDR_W - `SOC_TOP_SEL_W;
    localparam int BlockShift = `SOC_ADDR_W - `SOC_PERIPH_SEL_W;
    localparam int RegShift = `SOC_ADDR_W - `SOC_SMALL_SEL_W;

    logic w_SysClk;
    logic i_rst;
    busAddr_t i_busAddr;
    byteEn_t i_busByteEn;
    logic i_busRead;
    logic i_busWrite;
    busData_t i_busWriteData;
    busData_t o_busReadData;
    logic o_busWaitRequest;
    logic [2:0] o_sevenSegEn;
    logic [6:0] o_sevenSegLed;

    // Reference model state
    busData_t ramModel [`SOC_RAM_DEPTH];
    logic [2:0] segEnModel;
    logic [6:0] segLedModel;
    logic timerEnModel;
    busData_t countModel;
    busData_t compareModel;
    logic flagModel;

    busData_t rngState;
    int errorCount;
    int checkCount;
    string nameQ[$];
    busData_t expQ[$];
    busData_t actQ[$];

    socTop socTop_inst (.*);

    initial begin
        w_SysClk = 1'b0;
        forever #(ClkPeriod / 2) w_SysClk = ~w_SysClk;
    end

    function automatic busData_t nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState ^ (rngState >> 15);
    endfunction

    function automatic busAddr_t ramAddr(int offset);
        return (busAddr_t'(`SOC_TOP_PERIPH) << TopShift)
             | (busAddr_t'(`SOC_PERIPH_RAM) << BlockShift) | busAddr_t'(offset);
    endfunction

    function automatic busAddr_t smallAddr(int idx, int regOff);
        return (busAddr_t'(`SOC_TOP_PERIPH) << TopShift)
             | (busAddr_t'(`SOC_PERIPH_SMALL) << BlockShift)
             | (busAddr_t'(idx) << RegShift) | busAddr_t'(regOff);
    endfunction

    // Slave code is 0 for none, 1 RAM, 2 GPIO, 3 timer
    function automatic int slaveOf(busAddr_t addr);
        if ((addr >> TopShift) != `SOC_TOP_PERIPH) return 0;
        if (((addr >> BlockShift) & 'hFF) == `SOC_PERIPH_RAM) return 1;
        if (((addr >> BlockShift) & 'hFF) != `SOC_PERIPH_SMALL) return 0;
        if (((addr >> RegShift) & 'h3FF) == `SOC_SMALL_GPIO) return 2;
        if (((addr >> RegShift) & 'h3FF) == `SOC_SMALL_TIMER) return 3;
        return 0;
    endfunction

    function automatic busData_t applyByteEn(busData_t oldWord, busData_t newWord, byteEn_t be);
        busData_t result;
        result = oldWord;
        for (int b = 0; b < `SOC_BE_W; b++) begin
            if (be[b]) result[8*b +: 8] = newWord[8*b +: 8];
        end
        return result;
    endfunction

    function automatic void refWrite(busAddr_t addr, byteEn_t be, busData_t data);
        int regOff;
        int idx;
        regOff = int'(addr & 'h3FF);
        idx = int'(addr % `SOC_RAM_DEPTH);
        case (slaveOf(addr))
            1: ramModel[idx] = applyByteEn(ramModel[idx], data, be);
            2: begin
                if (be[0] && regOff == 0) segEnModel = data[2:0];
                if (be[0] && regOff == 1) segLedModel = data[6:0];
            end
            3: begin
                if (be[0] && regOff == 0) timerEnModel = data[0];
                if (regOff == 1) countModel = applyByteEn(countModel, data, be);
                if (regOff == 2) compareModel = applyByteEn(compareModel, data, be);
                // Status bit clears on a written 1
                if (regOff == 3 && be[0] && data[0]) flagModel = 1'b0;
            end
            default: ;
        endcase
    endfunction

    function automatic busData_t refRead(busAddr_t addr);
        int regOff;
        busData_t result;
        regOff = int'(addr & 'h3FF);
        result = '0;
        case (slaveOf(addr))
            1: result = ramModel[int'(addr % `SOC_RAM_DEPTH)];
            2: begin
                if (regOff == 0) result = busData_t'(segEnModel);
                if (regOff == 1) result = busData_t'(segLedModel);
            end
            3: begin
                if (regOff == 0) result = busData_t'(timerEnModel);
                if (regOff == 1) result = countModel;
                if (regOff == 2) result = compareModel;
                if (regOff == 3) result = busData_t'(flagModel);
            end
            default: ;
        endcase
        return result;
    endfunction

    task automatic checkValue(string name, busData_t expected, busData_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0d ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic void queueCheck(string name, busData_t expected, busData_t actual);
        nameQ.push_back(name);
        expQ.push_back(expected);
        actQ.push_back(actual);
    endfunction

    // Compare process drains the checks queued since the last edge
    always @(posedge w_SysClk) begin
        while (actQ.size() > 0) begin
            checkValue(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
        end
    end

    task automatic idleCycles(int cycles);
        repeat (cycles) @(posedge w_SysClk);
        #1;
    endtask

    task automatic busWrite(busAddr_t addr, byteEn_t be, busData_t data);
        int waits;
        waits = 0;
        refWrite(addr, be, data);
        i_busAddr = addr;
        i_busByteEn = be;
        i_busWriteData = data;
        i_busWrite = 1'b1;
        @(negedge w_SysClk);
        while (o_busWaitRequest) begin
            waits++;
            @(negedge w_SysClk);
        end
        // Every write completes in one cycle
        queueCheck("o_busWaitRequest write cycles", 32'd0, busData_t'(waits));
        @(posedge w_SysClk);
        #1;
        i_busWrite = 1'b0;
    endtask

    task automatic busRead(busAddr_t addr, output busData_t data, output int waits);
        waits = 0;
        i_busAddr = addr;
        i_busRead = 1'b1;
        @(negedge w_SysClk);
        while (o_busWaitRequest) begin
            waits++;
            @(negedge w_SysClk);
        end
        data = o_busReadData;
        @(posedge w_SysClk);
        #1;
        i_busRead = 1'b0;
    endtask

    task automatic readCheck(string name, busAddr_t addr, int expWaits);
        busData_t data;
        int waits;
        busRead(addr, data, waits);
        queueCheck({name, " o_busReadData"}, refRead(addr), data);
        queueCheck({name, " o_busWaitRequest cycles"}, busData_t'(expWaits),
                   busData_t'(waits));
    endtask

    task automatic portCheck();
        queueCheck("o_sevenSegEn", busData_t'(segEnModel), busData_t'(o_sevenSegEn));
        queueCheck("o_sevenSegLed", busData_t'(segLedModel), busData_t'(o_sevenSegLed));
    endtask

    initial begin
        repeat (TimeoutCycles) @(posedge w_SysClk);
        $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int offsets [RamWrites];
        busData_t c1;
        busData_t c2;
        int waits;
        busAddr_t addr;
        rngState = 32'd51655;
        errorCount = 0;
        checkCount = 0;
        {segEnModel, segLedModel, timerEnModel, flagModel} = '0;
        countModel = '0;
        compareModel = '0;
        i_rst = 1'b1;
        i_busAddr = '0;
        i_busByteEn = '0;
        i_busRead = 1'b0;
        i_busWrite = 1'b0;
        i_busWriteData = '0;
        repeat (ResetCycles) @(posedge w_SysClk);
        #1;
        i_rst = 1'b0;
        idleCycles(2);

        // Reset state of the bus, display and timer
        queueCheck("o_busWaitRequest", 32'd0, busData_t'(o_busWaitRequest));
        portCheck();
        readCheck("timerCtrlRst", smallAddr(`SOC_SMALL_TIMER, 0), 0);
        readCheck("timerCountRst", smallAddr(`SOC_SMALL_TIMER, 1), 0);
        readCheck("timerCmpRst", smallAddr(`SOC_SMALL_TIMER, 2), 0);
        readCheck("timerStatusRst", smallAddr(`SOC_SMALL_TIMER, 3), 0);

        // RAM round trip
        for (int i = 0; i < RamWrites; i++) begin
            offsets[i] = int'(nextRand() % `SOC_RAM_DEPTH);
            busWrite(ramAddr(offsets[i]), 4'hF, nextRand());
        end
        for (int i = 0; i < RamWrites; i++) readCheck("ramWord", ramAddr(offsets[i]), 1);

        // Partial writes over known words
        for (int i = 0; i < ByteEnWrites; i++) begin
            busWrite(ramAddr(offsets[i]), byteEn_t'(nextRand()), nextRand());
            readCheck("ramByteEn", ramAddr(offsets[i]), 1);
        end

        // GPIO registers and display ports
        busWrite(smallAddr(`SOC_SMALL_GPIO, 0), 4'h1, nextRand());
        busWrite(smallAddr(`SOC_SMALL_GPIO, 1), 4'hF, nextRand());
        portCheck();
        readCheck("gpioEn", smallAddr(`SOC_SMALL_GPIO, 0), 0);
        readCheck("gpioLed", smallAddr(`SOC_SMALL_GPIO, 1), 0);
        busWrite(smallAddr(`SOC_SMALL_GPIO, 1), 4'hE, nextRand());
        portCheck();
        readCheck("gpioLedMasked", smallAddr(`SOC_SMALL_GPIO, 1), 0);
        readCheck("gpioUnused", smallAddr(`SOC_SMALL_GPIO, 2), 0);

        // Timer counting
        busWrite(smallAddr(`SOC_SMALL_TIMER, 1), 4'hF, 32'd100);
        readCheck("timerCount", smallAddr(`SOC_SMALL_TIMER, 1), 0);
        busWrite(smallAddr(`SOC_SMALL_TIMER, 0), 4'h1, 32'd1);
        busRead(smallAddr(`SOC_SMALL_TIMER, 1), c1, waits);
        idleCycles(CountGap - 1);
        busRead(smallAddr(`SOC_SMALL_TIMER, 1), c2, waits);
        queueCheck("countDelta o_busReadData", busData_t'(CountGap), c2 - c1);
        busWrite(smallAddr(`SOC_SMALL_TIMER, 0), 4'h1, 32'd0);
        // Still enabled on the read edge and on the disabling edge
        countModel = 32'd100 + CountGap + 2;
        idleCycles(5);
        readCheck("timerCountHeld", smallAddr(`SOC_SMALL_TIMER, 1), 0);

        // Match flag set and then cleared
        busWrite(smallAddr(`SOC_SMALL_TIMER, 2), 4'hF, countModel + 6);
        busWrite(smallAddr(`SOC_SMALL_TIMER, 0), 4'h1, 32'd1);
        idleCycles(12);
        busWrite(smallAddr(`SOC_SMALL_TIMER, 0), 4'h1, 32'd0);
        flagModel = 1'b1;
        readCheck("timerStatus", smallAddr(`SOC_SMALL_TIMER, 3), 0);
        busWrite(smallAddr(`SOC_SMALL_TIMER, 3), 4'h1, 32'd1);
        readCheck("timerStatusClr", smallAddr(`SOC_SMALL_TIMER, 3), 0);

        // Unmapped region 0 aliasing a RAM word, and an unused small index
        addr = busAddr_t'(offsets[0]) | (busAddr_t'(nextRand()) & busAddr_t'('h000F_FC00));
        readCheck("unmappedRegion", addr, 0);
        busWrite(addr, 4'hF, nextRand());
        readCheck("unusedIndex", smallAddr(5, 1), 0);
        busWrite(smallAddr(5, 1), 4'hF, nextRand());
        for (int i = 0; i < 8; i++) readCheck("ramIntact", ramAddr(offsets[i]), 1);
        readCheck("gpioEnIntact", smallAddr(`SOC_SMALL_GPIO, 0), 0);
        readCheck("timerCmpIntact", smallAddr(`SOC_SMALL_TIMER, 2), 0);
        readCheck("timerCtrlIntact", smallAddr(`SOC_SMALL_TIMER, 0), 0);
        portCheck();

        idleCycles(3);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+include
source/socPkg.sv
source/slaveBusIf.sv
source/dbusDecoder.sv
source/ramSlave.sv
source/sevenSegGpio.sv
source/timerSlave.sv
source/socTop.sv
test/socTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module socTb -f list.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
